//--- project.f
+incdir+hdl
hdl/wdata_arb_pkg.sv
hdl/slot_if.sv
hdl/slot_tracker.sv
hdl/rr_slot_arbiter.sv
hdl/w_output_stage.sv
hdl/wdata_arbiter_top.sv
test/wdata_arbiter_assert.sv
test/wdata_arbiter_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module wdata_arbiter_tb \
    -f project.f \
    -o wdata_arbiter_sim

sim_output=$(./obj_dir/wdata_arbiter_sim)
echo "$sim_output"

if echo "$sim_output" | grep -q "^Regression passed$"; then
    exit 0
else
    exit 1
fi

//--- test/wdata_arbiter_tb.sv
// table-driven testbench for the write-data arbiter, compiled with project.f and run by run.sh
`default_nettype none

`include "wdata_arb_params.svh"

module wdata_arbiter_tb;
    import wdata_arb_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_SRC    = `WARB_NUM_SRC;
    localparam int NUM_SLOT   = `WARB_NUM_SLOT;

    // one row is one cycle of stimulus plus the beat expected on the master port
    typedef struct packed {
        slot_mask_t                 slot_valid;
        wlen_t                      wlen0;
        src_mask_t                  src_valid;
        wid_t [`WARB_NUM_SRC-1:0]   src_wid;
        logic                       m_ready;
        logic                       hold;
        logic                       exp_valid;
        wid_t                       exp_wid;
        src_idx_t                   exp_src;
        logic                       exp_wlast;
    } row_t;

    logic       clk;
    logic       rst_n;
    wid_t       src_wid   [`WARB_NUM_SRC];
    wdata_t     src_wdata [`WARB_NUM_SRC];
    wstrb_t     src_wstrb [`WARB_NUM_SRC];
    src_mask_t  src_wlast;
    src_mask_t  src_valid;
    src_mask_t  src_ready;
    slot_mask_t slot_valid;
    wid_t       slot_id   [`WARB_NUM_SLOT];
    wlen_t      slot_wlen [`WARB_NUM_SLOT];
    wid_t       m_wid;
    wdata_t     m_wdata;
    wstrb_t     m_wstrb;
    logic       m_wlast;
    logic       m_valid;
    logic       m_ready;

    wid_t       got_wid;
    wdata_t     got_wdata;
    wstrb_t     got_wstrb;
    logic       got_wlast;
    logic       got_valid;
    src_mask_t  got_ready;

    row_t       rows[$];
    string      row_name[$];
    integer     seed = 32'h5fb6;
    int         err_cnt = 0;
    int         test_cnt = 0;
    int         fail_cnt = 0;
    int         cycle_cnt = 0;
    int         cycle_limit = 0;

    wdata_arbiter_top i_dut (.*);

    bind wdata_arbiter_top wdata_arbiter_assert i_assert (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_wid     (m_wid),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wlast   (m_wlast),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .src_ready (src_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: the test table did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // codes 0..2 give a valid source with that slot's ID and a..c the same ID but not valid
    // while x gives a valid source with an ID no slot uses and any other code leaves it idle
    function automatic wid_t wid_for_code(input byte c);
        case (c)
            "0", "a": return 6'h11;
            "1", "b": return 6'h22;
            "2", "c": return 6'h33;
            default:  return 6'h3f;
        endcase
    endfunction

    task automatic add_row(input string name, input slot_mask_t sv, input wlen_t wlen0,
                           input string srcs, input logic rdy, input logic hold,
                           input logic ev, input byte eslot, input int esrc,
                           input logic ewlast);
        row_t r;
        r = '0;
        r.slot_valid = sv;
        r.wlen0      = wlen0;
        for (int i = 0; i < NUM_SRC; i++) begin
            r.src_wid[i]   = wid_for_code(srcs[i]);
            r.src_valid[i] = srcs[i] inside {"0", "1", "2", "x"};
        end
        r.m_ready   = rdy;
        r.hold      = hold;
        r.exp_valid = ev;
        r.exp_wid   = wid_for_code(eslot);
        r.exp_src   = src_idx_t'(esrc);
        r.exp_wlast = ewlast;
        rows.push_back(r);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        add_row("reset_idle",       3'b000, 8'd0, ".........", 1'b1, 1'b0, 1'b0, "-", 0, 1'b0);
        // every slot requests, so the pointer alone picks the slot
        add_row("rr_slot0",         3'b111, 8'd0, "0...1...2", 1'b1, 1'b0, 1'b1, "0", 0, 1'b1);
        add_row("rr_slot1",         3'b111, 8'd0, "0...1...2", 1'b1, 1'b0, 1'b1, "1", 4, 1'b1);
        add_row("rr_slot2",         3'b111, 8'd0, "0...1...2", 1'b1, 1'b0, 1'b1, "2", 8, 1'b1);
        add_row("rr_wrap",          3'b111, 8'd0, "0...1...2", 1'b1, 1'b0, 1'b1, "0", 0, 1'b1);
        add_row("single_match",     3'b111, 8'd0, ".....2...", 1'b1, 1'b0, 1'b1, "2", 5, 1'b1);
        add_row("no_match_id",      3'b111, 8'd0, "xxxxxxxxx", 1'b1, 1'b0, 1'b0, "-", 0, 1'b0);
        add_row("no_match_invalid", 3'b111, 8'd0, "a...b...c", 1'b1, 1'b0, 1'b0, "-", 0, 1'b0);
        add_row("lowest_src",       3'b111, 8'd0, "...1x.1..", 1'b1, 1'b0, 1'b1, "1", 3, 1'b1);
        add_row("stall_0",          3'b111, 8'd0, "0...1...2", 1'b0, 1'b0, 1'b1, "2", 8, 1'b1);
        add_row("stall_1",          3'b111, 8'd0, "0...1...2", 1'b0, 1'b1, 1'b1, "2", 8, 1'b1);
        add_row("stall_2",          3'b111, 8'd0, "0...1...2", 1'b0, 1'b1, 1'b1, "2", 8, 1'b1);
        add_row("stall_release",    3'b111, 8'd0, "0...1...2", 1'b1, 1'b1, 1'b1, "2", 8, 1'b1);
        add_row("after_stall",      3'b111, 8'd0, "0...1...2", 1'b1, 1'b0, 1'b1, "0", 0, 1'b1);
        // slot 0 drops so its next rise loads a four beat burst
        add_row("burst_idle",       3'b000, 8'd0, ".........", 1'b1, 1'b0, 1'b0, "-", 0, 1'b0);
        add_row("burst_beat0",      3'b001, 8'd3, "..0......", 1'b1, 1'b0, 1'b1, "0", 2, 1'b0);
        add_row("burst_beat1",      3'b001, 8'd3, "..0......", 1'b1, 1'b0, 1'b1, "0", 2, 1'b0);
        add_row("burst_beat2",      3'b001, 8'd3, "..0......", 1'b1, 1'b0, 1'b1, "0", 2, 1'b0);
        add_row("burst_last",       3'b001, 8'd3, "..0......", 1'b1, 1'b0, 1'b1, "0", 2, 1'b1);
    endtask

    task automatic drive_idle();
        for (int i = 0; i < NUM_SRC; i++) begin
            src_wid[i]   = '0;
            src_wdata[i] = '0;
            src_wstrb[i] = '0;
        end
        for (int s = 0; s < NUM_SLOT; s++) begin
            slot_wlen[s] = '0;
        end
        slot_id[0] = wid_for_code("0");
        slot_id[1] = wid_for_code("1");
        slot_id[2] = wid_for_code("2");
        src_wlast  = '0;
        src_valid  = '0;
        slot_valid = '0;
        m_ready    = 1'b0;
        rst_n      = 1'b0;
    endtask

    task automatic apply_row(input row_t r);
        slot_valid   = r.slot_valid;
        slot_wlen[0] = r.wlen0;
        src_valid    = r.src_valid;
        src_wlast    = '0;
        m_ready      = r.m_ready;
        for (int i = 0; i < NUM_SRC; i++) begin
            src_wid[i] = r.src_wid[i];
            // a stalled beat must keep its payload, so data is only renewed on fresh rows
            if (!r.hold) begin
                src_wdata[i] = $random(seed);
                src_wstrb[i] = wstrb_t'($random(seed));
            end
        end
    endtask

    task automatic sample_outputs();
        got_wid   = m_wid;
        got_wdata = m_wdata;
        got_wstrb = m_wstrb;
        got_wlast = m_wlast;
        got_valid = m_valid;
        got_ready = src_ready;
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", name, field, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_row(input string name, input row_t r);
        int        errs_before;
        src_mask_t exp_ready;
        errs_before = err_cnt;
        exp_ready   = (r.exp_valid && r.m_ready) ? (src_mask_t'(1) << r.exp_src) : '0;
        compare_field(name, "m_valid", 32'(r.exp_valid), 32'(got_valid));
        if (r.exp_valid) begin
            compare_field(name, "m_wid", 32'(r.exp_wid), 32'(got_wid));
            compare_field(name, "m_wdata", src_wdata[r.exp_src], got_wdata);
            compare_field(name, "m_wstrb", 32'(src_wstrb[r.exp_src]), 32'(got_wstrb));
            compare_field(name, "m_wlast", 32'(r.exp_wlast), 32'(got_wlast));
        end
        compare_field(name, "src_ready", 32'(exp_ready), 32'(got_ready));
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: FAILED", name);
        end
    endtask

    initial begin
        drive_idle();
        build_table();
        cycle_limit = rows.size() * 4 + 50;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < rows.size(); t++) begin
            apply_row(rows[t]);
            // outputs are combinational, read them just before the edge that takes the beat
            #(CLK_PERIOD / 2 - 1);
            sample_outputs();
            @(posedge clk);
            check_row(row_name[t], rows[t]);
            @(negedge clk);
        end
        $display("tests run: %0d, tests failed: %0d, errors: %0d, assertion failures: %0d",
                 test_cnt, fail_cnt, err_cnt, i_dut.i_assert.fail_cnt);
        if (err_cnt == 0 && i_dut.i_assert.fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/wdata_arbiter_assert.sv
// concurrent checks on the master W port and source ready, bound into the arbiter top level
`default_nettype none

module wdata_arbiter_assert (
    input logic                     clk,
    input logic                     rst_n,
    input wdata_arb_pkg::wid_t      m_wid,
    input wdata_arb_pkg::wdata_t    m_wdata,
    input wdata_arb_pkg::wstrb_t    m_wstrb,
    input logic                     m_wlast,
    input logic                     m_valid,
    input logic                     m_ready,
    input wdata_arb_pkg::src_mask_t src_ready
);

    int fail_cnt = 0;

    // only the served source may see ready
    one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(src_ready))
        else begin
            $error("more than one source was given ready in the same cycle");
            fail_cnt++;
        end

    ready_needs_master: assert property (@(posedge clk) disable iff (!rst_n)
        |src_ready |-> m_ready)
        else begin
            $error("a source was given ready while the master port was stalled");
            fail_cnt++;
        end

    // a stalled beat stays on the port unchanged until it is taken
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_wid) && $stable(m_wdata)
            && $stable(m_wstrb) && $stable(m_wlast))
        else begin
            $error("the master beat changed or vanished while it was stalled");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- hdl/wdata_arbiter_top.sv
// write-data arbiter top level, connecting nine source FIFOs to one AXI W master port
`default_nettype none

`include "wdata_arb_params.svh"

module wdata_arbiter_top (
    input  logic                      clk,
    input  logic                      rst_n,

    // source FIFO heads, three per upstream slave port
    input  wdata_arb_pkg::wid_t       src_wid   [`WARB_NUM_SRC],
    input  wdata_arb_pkg::wdata_t     src_wdata [`WARB_NUM_SRC],
    input  wdata_arb_pkg::wstrb_t     src_wstrb [`WARB_NUM_SRC],
    input  wdata_arb_pkg::src_mask_t  src_wlast,
    input  wdata_arb_pkg::src_mask_t  src_valid,
    output wdata_arb_pkg::src_mask_t  src_ready,

    // outstanding write slots from the address log table
    input  wdata_arb_pkg::slot_mask_t slot_valid,
    input  wdata_arb_pkg::wid_t       slot_id   [`WARB_NUM_SLOT],
    input  wdata_arb_pkg::wlen_t      slot_wlen [`WARB_NUM_SLOT],

    // W master port
    output wdata_arb_pkg::wid_t       m_wid,
    output wdata_arb_pkg::wdata_t     m_wdata,
    output wdata_arb_pkg::wstrb_t     m_wstrb,
    output logic                      m_wlast,
    output logic                      m_valid,
    input  logic                      m_ready
);
    import wdata_arb_pkg::*;

    slot_mask_t slot_req;
    slot_mask_t grant;

    slot_if slot_bus [`WARB_NUM_SLOT] ();

    for (genvar g = 0; g < `WARB_NUM_SLOT; g++) begin : g_slot
        slot_tracker i_tracker (
            .clk        (clk),
            .rst_n      (rst_n),
            .slot_valid (slot_valid[g]),
            .slot_id    (slot_id[g]),
            .slot_wlen  (slot_wlen[g]),
            .src_wid    (src_wid),
            .src_wdata  (src_wdata),
            .src_wstrb  (src_wstrb),
            .src_wlast  (src_wlast),
            .src_valid  (src_valid),
            .slot       (slot_bus[g])
        );

        assign slot_req[g] = slot_bus[g].req;
    end

    rr_slot_arbiter i_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (slot_req),
        .m_ready (m_ready),
        .grant   (grant)
    );

    w_output_stage i_output (
        .grant     (grant),
        .m_ready   (m_ready),
        .slot0     (slot_bus[0]),
        .slot1     (slot_bus[1]),
        .slot2     (slot_bus[2]),
        .m_wid     (m_wid),
        .m_wdata   (m_wdata),
        .m_wstrb   (m_wstrb),
        .m_wlast   (m_wlast),
        .m_valid   (m_valid),
        .src_ready (src_ready)
    );

endmodule

`default_nettype wire

//--- hdl/w_output_stage.sv
// drives the master W port from the granted slot and routes ready back to its source
`default_nettype none

`include "wdata_arb_params.svh"

module w_output_stage (
    input  wdata_arb_pkg::slot_mask_t grant,
    input  logic                      m_ready,
    slot_if.sink                      slot0,
    slot_if.sink                      slot1,
    slot_if.sink                      slot2,
    output wdata_arb_pkg::wid_t       m_wid,
    output wdata_arb_pkg::wdata_t     m_wdata,
    output wdata_arb_pkg::wstrb_t     m_wstrb,
    output logic                      m_wlast,
    output logic                      m_valid,
    output wdata_arb_pkg::src_mask_t  src_ready
);
    import wdata_arb_pkg::*;

    wid_t       s_wid   [`WARB_NUM_SLOT];
    wdata_t     s_wdata [`WARB_NUM_SLOT];
    wstrb_t     s_wstrb [`WARB_NUM_SLOT];
    slot_mask_t s_wlast;
    src_idx_t   s_sel   [`WARB_NUM_SLOT];
    slot_mask_t take;

    assign s_wid   = '{slot0.wid, slot1.wid, slot2.wid};
    assign s_wdata = '{slot0.wdata, slot1.wdata, slot2.wdata};
    assign s_wstrb = '{slot0.wstrb, slot1.wstrb, slot2.wstrb};
    assign s_sel   = '{slot0.src_sel, slot1.src_sel, slot2.src_sel};
    assign s_wlast = {slot2.wlast, slot1.wlast, slot0.wlast};

    assign take         = grant & {`WARB_NUM_SLOT{m_ready}};
    assign slot0.accept = take[0];
    assign slot1.accept = take[1];
    assign slot2.accept = take[2];

    assign m_valid = |grant;

    always_comb begin
        m_wid     = '0;
        m_wdata   = '0;
        m_wstrb   = '0;
        m_wlast   = 1'b0;
        src_ready = '0;
        for (int s = 0; s < `WARB_NUM_SLOT; s++) begin
            if (grant[s]) begin
                m_wid   = s_wid[s];
                m_wdata = s_wdata[s];
                m_wstrb = s_wstrb[s];
                m_wlast = s_wlast[s];
            end
            if (take[s]) begin
                src_ready[s_sel[s]] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rr_slot_arbiter.sv
// round-robin grant over the write slots, frozen while the master port stalls
`default_nettype none

`include "wdata_arb_params.svh"

module rr_slot_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  wdata_arb_pkg::slot_mask_t req,
    input  logic                      m_ready,
    output wdata_arb_pkg::slot_mask_t grant
);
    import wdata_arb_pkg::*;

    localparam int N = `WARB_NUM_SLOT;

    arb_state_t         state;
    slot_mask_t         ptr;
    slot_mask_t         grant_q;
    slot_mask_t         grant_free;
    logic [2*N-1:0]     req_dbl;
    logic [2*N-1:0]     gnt_dbl;
    logic               beat_valid;

    // subtracting the one-hot pointer from the doubled request clears everything below
    // the first request at or after the pointer, the upper half handles wrap-around
    assign req_dbl    = {req, req};
    assign gnt_dbl    = req_dbl & ~(req_dbl - {{N{1'b0}}, ptr});
    assign grant_free = gnt_dbl[2*N-1:N] | gnt_dbl[N-1:0];

    assign grant      = (state == ARB_HELD) ? grant_q : grant_free;
    assign beat_valid = |grant;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ARB_FREE;
            grant_q <= '0;
        end else begin
            case (state)
                ARB_FREE: begin
                    if (beat_valid && !m_ready) begin
                        state   <= ARB_HELD;
                        grant_q <= grant_free;
                    end
                end
                ARB_HELD: begin
                    if (m_ready) begin
                        state <= ARB_FREE;
                    end
                end
                default: state <= ARB_FREE;
            endcase
        end
    end

    // after a transfer the slot following the served one gets first claim
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= slot_mask_t'(1);
        end else if (beat_valid && m_ready) begin
            ptr <= {grant[N-2:0], grant[N-1]};
        end
    end

endmodule

`default_nettype wire

//--- hdl/slot_tracker.sv
// matches one write slot's ID against all source FIFOs and counts the beats of its burst
`default_nettype none

`include "wdata_arb_params.svh"

module slot_tracker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      slot_valid,
    input  wdata_arb_pkg::wid_t       slot_id,
    input  wdata_arb_pkg::wlen_t      slot_wlen,
    input  wdata_arb_pkg::wid_t       src_wid   [`WARB_NUM_SRC],
    input  wdata_arb_pkg::wdata_t     src_wdata [`WARB_NUM_SRC],
    input  wdata_arb_pkg::wstrb_t     src_wstrb [`WARB_NUM_SRC],
    input  wdata_arb_pkg::src_mask_t  src_wlast,
    input  wdata_arb_pkg::src_mask_t  src_valid,
    slot_if.tracker                   slot
);
    import wdata_arb_pkg::*;

    src_mask_t match;
    src_idx_t  sel;
    logic      valid_q;
    logic      valid_rise;
    wlen_t     beat_cnt;
    wlen_t     beat_cnt_eff;

    always_comb begin
        for (int i = 0; i < `WARB_NUM_SRC; i++) begin
            match[i] = slot_valid && src_valid[i] && (src_wid[i] == slot_id);
        end
    end

    // scan from the top so the lowest matching source is the one left in sel
    always_comb begin
        sel = '0;
        for (int i = `WARB_NUM_SRC - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel = src_idx_t'(i);
            end
        end
    end

    assign slot.req     = |match;
    assign slot.src_sel = sel;
    assign slot.wid     = src_wid[sel];
    assign slot.wdata   = src_wdata[sel];
    assign slot.wstrb   = src_wstrb[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= slot_valid;
        end
    end

    assign valid_rise = slot_valid && !valid_q;

    // the register still holds the previous burst during the first cycle of a new one
    assign beat_cnt_eff = valid_rise ? slot_wlen : beat_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (valid_rise) begin
            beat_cnt <= (slot.accept && slot_wlen != '0) ? slot_wlen - wlen_t'(1) : slot_wlen;
        end else if (slot.accept && beat_cnt != '0) begin
            beat_cnt <= beat_cnt - wlen_t'(1);
        end
    end

    // final beat of the burst is marked even if the source leaves wlast low
    assign slot.wlast = src_wlast[sel] || (beat_cnt_eff == '0);

endmodule

`default_nettype wire

//--- hdl/slot_if.sv
// one slot's selected W beat and request, passed from a slot tracker to the output stage
`default_nettype none

interface slot_if;
    import wdata_arb_pkg::*;

    logic     req;
    src_idx_t src_sel;
    wid_t     wid;
    wdata_t   wdata;
    wstrb_t   wstrb;
    logic     wlast;
    // the master took this slot's beat in the current cycle
    logic     accept;

    modport tracker (
        output req,
        output src_sel,
        output wid,
        output wdata,
        output wstrb,
        output wlast,
        input  accept
    );

    modport sink (
        input  req,
        input  src_sel,
        input  wid,
        input  wdata,
        input  wstrb,
        input  wlast,
        output accept
    );

endinterface

`default_nettype wire

//--- hdl/wdata_arb_pkg.sv
// shared vector types and the arbiter state enum, imported by every arbiter module
`default_nettype none

`include "wdata_arb_params.svh"

package wdata_arb_pkg;

    typedef logic [`WARB_ID_W-1:0]      wid_t;
    typedef logic [`WARB_DATA_W-1:0]    wdata_t;
    typedef logic [`WARB_STRB_W-1:0]    wstrb_t;
    // AXI length encoding, beats minus one
    typedef logic [`WARB_LEN_W-1:0]     wlen_t;
    typedef logic [`WARB_SRC_IDX_W-1:0] src_idx_t;
    typedef logic [`WARB_NUM_SRC-1:0]   src_mask_t;
    typedef logic [`WARB_NUM_SLOT-1:0]  slot_mask_t;

    typedef enum logic [0:0] {
        ARB_FREE,
        ARB_HELD
    } arb_state_t;

endpackage

`default_nettype wire

//--- hdl/wdata_arb_params.svh
// sizing macros for the write-data arbiter, included by the package and the testbench
`ifndef WDATA_ARB_PARAMS_SVH
`define WDATA_ARB_PARAMS_SVH

// three slave ports with three write-data FIFOs each, flattened
`define WARB_NUM_SRC 9

// outstanding write slots offered by the address log table
`define WARB_NUM_SLOT 3

`define WARB_ID_W 6
`define WARB_DATA_W 32
`define WARB_STRB_W 4
`define WARB_LEN_W 8

// wide enough to index every source FIFO
`define WARB_SRC_IDX_W 4

`endif
